/* sources.f */
verilog/xbar_pkg.sv
verilog/xbar.sv
verilog/clint.sv
verilog/soc_sram.sv
verilog/mem_subsys.sv
sim/tb_mem_subsys.sv

/* Makefile */
# Verilator build and run for the memory subsystem testbench.

VERILATOR ?= verilator
TOP       ?= tb_mem_subsys
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= Simulation completed successfully
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(wildcard verilog/*.sv) $(wildcard sim/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The run passes only if the log holds the pass message.
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sim/tb_input.txt */
// op addr wdata strb exp_data exp_resp (hex). 1 store, 2 load, 3 fetch,
// 4 fetch raised with the load on the next line, 5 mtime low rising, 0 end.
2 0200bffc 00000000 0 00000000 0
5 0200bff8 00000000 0 00000000 0
5 0200bff8 00000000 0 00000000 0
// Both lanes of word 0, then partial strobes.
1 80000000 11223344 f 00000000 0
1 80000004 55667788 f 00000000 0
1 80000000 aabbccdd 5 00000000 0
1 80000004 01020304 a 00000000 0
2 80000000 00000000 0 11bb33dd 0
2 80000004 00000000 0 01660388 0
3 80000000 00000000 0 11bb33dd 0
3 80000004 00000000 0 01660388 0
// Word 5 for the tied reads.
1 80000028 deadbeef f 00000000 0
1 8000002c 0badf00d f 00000000 0
4 80000028 00000000 0 deadbeef 0
2 80000004 00000000 0 01660388 0
4 8000002c 00000000 0 0badf00d 0
2 0200bffc 00000000 0 00000000 0
// Outside both windows.
1 40000000 cafef00d f 00000000 3
2 40000000 00000000 0 00000000 3
1 02000000 12345678 f 00000000 3
2 02000000 00000000 0 00000000 3
3 10000000 00000000 0 00000000 3
// Would alias word 0 if it were stored.
1 80000800 ffffffff f 00000000 3
2 80000000 00000000 0 11bb33dd 0
3 8000002c 00000000 0 0badf00d 0
5 0200bff8 00000000 0 00000000 0
0 00000000 00000000 0 00000000 0

/* sim/tb_mem_subsys.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_mem_subsys
	import xbar_pkg::*;
();

	logic        clock;
	logic        rst_n;

	logic [31:0] ifu_araddr;
	logic        ifu_arvalid;
	wire         ifu_arready;
	wire  [31:0] ifu_rdata;
	wire  [1:0]  ifu_rresp;
	wire         ifu_rvalid;
	logic        ifu_rready = 1'b1;

	logic [31:0] lsu_araddr;
	logic        lsu_arvalid;
	logic [2:0]  lsu_arsize;
	wire         lsu_arready;
	wire  [31:0] lsu_rdata;
	wire  [1:0]  lsu_rresp;
	wire         lsu_rvalid;
	logic        lsu_rready = 1'b1;

	logic [31:0] lsu_awaddr;
	logic        lsu_awvalid;
	logic [2:0]  lsu_awsize;
	wire         lsu_awready;
	logic [31:0] lsu_wdata;
	logic [3:0]  lsu_wstrb;
	logic        lsu_wvalid;
	wire         lsu_wready;
	wire  [1:0]  lsu_bresp;
	wire         lsu_bvalid;
	logic        lsu_bready = 1'b1;

	logic [31:0] stim [384]; // 64 entries of six words.
	int          entry_count;
	int          error_count = 0;
	int          cycle_count = 0;
	int          cycle_limit = 0;
	logic [31:0] lfsr = 32'h011dcf4a;
	logic        ifu_rd_pending = 1'b0;
	logic        lsu_rd_pending = 1'b0;
	logic        lsu_wr_pending = 1'b0;
	time         ifu_done_time, lsu_done_time;

	mem_subsys i_mem_subsys (.*);

	initial clock = 1'b0;
	always #4 clock = ~clock;

	// Taps 32, 22, 2, 1.
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	// Random back-pressure on every response channel.
	always @(posedge clock) begin
		#1;
		lfsr = lfsr_next(lfsr);
		ifu_rready = lfsr[0];
		lfsr = lfsr_next(lfsr);
		lsu_rready = lfsr[0];
		lfsr = lfsr_next(lfsr);
		lsu_bready = lfsr[0];
	end

	always @(posedge clock) begin
		cycle_count++;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			$display("Timeout: transactions still open after %0d cycles", cycle_count);
			$display("Errors: %0d", error_count);
			$display("Simulation failed");
			$finish;
		end
	end

	// A response must only reach the initiator that is waiting for one.
	always @(negedge clock) begin
		if (rst_n && ifu_rvalid && !ifu_rd_pending) begin
			$display("ERROR at %0t: fetch response with no fetch read outstanding", $time);
			error_count++;
		end
		if (rst_n && lsu_rvalid && !lsu_rd_pending) begin
			$display("ERROR at %0t: load response with no load outstanding", $time);
			error_count++;
		end
		if (rst_n && lsu_bvalid && !lsu_wr_pending) begin
			$display("ERROR at %0t: write response with no write outstanding", $time);
			error_count++;
		end
	end

	task automatic report_mismatch(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		$display("MISMATCH at %0t: %s expected %h, got %h", $time, name, expected, actual);
		error_count++;
	endtask

	task automatic fetch_read(input logic [31:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		@(posedge clock);
		#1;
		ifu_araddr     = addr;
		ifu_arvalid    = 1'b1;
		ifu_rd_pending = 1'b1;
		@(negedge clock);
		while (!ifu_arready)
			@(negedge clock);
		@(posedge clock);
		#1;
		ifu_arvalid = 1'b0;
		@(negedge clock);
		while (!(ifu_rvalid && ifu_rready))
			@(negedge clock);
		data          = ifu_rdata;
		resp          = ifu_rresp;
		ifu_done_time = $time;
		@(posedge clock);
		#1;
		ifu_rd_pending = 1'b0;
	endtask

	task automatic load_read(input logic [31:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		@(posedge clock);
		#1;
		lsu_araddr     = addr;
		lsu_arsize     = 3'd2;
		lsu_arvalid    = 1'b1;
		lsu_rd_pending = 1'b1;
		@(negedge clock);
		while (!lsu_arready)
			@(negedge clock);
		@(posedge clock);
		#1;
		lsu_arvalid = 1'b0;
		@(negedge clock);
		while (!(lsu_rvalid && lsu_rready))
			@(negedge clock);
		data          = lsu_rdata;
		resp          = lsu_rresp;
		lsu_done_time = $time;
		@(posedge clock);
		#1;
		lsu_rd_pending = 1'b0;
	endtask

	// Address and data channels complete independently.
	task automatic store_write(input logic [31:0] addr, input logic [31:0] data,
			input logic [3:0] strb, output logic [1:0] resp);
		logic aw_done;
		logic w_done;
		aw_done = 1'b0;
		w_done  = 1'b0;
		@(posedge clock);
		#1;
		lsu_awaddr     = addr;
		lsu_awsize     = 3'd2;
		lsu_awvalid    = 1'b1;
		lsu_wdata      = data;
		lsu_wstrb      = strb;
		lsu_wvalid     = 1'b1;
		lsu_wr_pending = 1'b1;
		while (!(aw_done && w_done)) begin
			@(negedge clock);
			if (lsu_awvalid && lsu_awready)
				aw_done = 1'b1;
			if (lsu_wvalid && lsu_wready)
				w_done = 1'b1;
			@(posedge clock);
			#1;
			if (aw_done)
				lsu_awvalid = 1'b0;
			if (w_done)
				lsu_wvalid = 1'b0;
		end
		@(negedge clock);
		while (!(lsu_bvalid && lsu_bready))
			@(negedge clock);
		resp = lsu_bresp;
		@(posedge clock);
		#1;
		lsu_wr_pending = 1'b0;
	endtask

	initial begin
		logic [31:0] op, addr, wdata, strb, exp_data, exp_resp;
		logic [31:0] rdata, rdata2, last_mtime;
		logic [1:0]  resp, resp2;
		logic        have_mtime;
		int          base;

		rst_n       = 1'b0;
		ifu_araddr  = 32'h0;
		ifu_arvalid = 1'b0;
		lsu_araddr  = 32'h0;
		lsu_arvalid = 1'b0;
		lsu_arsize  = 3'd2;
		lsu_awaddr  = 32'h0;
		lsu_awvalid = 1'b0;
		lsu_awsize  = 3'd2;
		lsu_wdata   = 32'h0;
		lsu_wstrb   = 4'h0;
		lsu_wvalid  = 1'b0;
		have_mtime  = 1'b0;
		last_mtime  = 32'h0;

		for (int i = 0; i < 384; i++)
			stim[i] = 32'hf000_0000 | i; // Invalid op if the end line is missing.
		$readmemh("sim/tb_input.txt", stim);
		entry_count = 0;
		while (entry_count < 64 && stim[6 * entry_count] != 32'h0)
			entry_count++;
		cycle_limit = 64 * entry_count + 100;

		repeat (16) @(posedge clock);
		#1;
		rst_n = 1'b1;

		for (int n = 0; n < entry_count; n++) begin
			base     = 6 * n;
			op       = stim[base];
			addr     = stim[base + 1];
			wdata    = stim[base + 2];
			strb     = stim[base + 3];
			exp_data = stim[base + 4];
			exp_resp = stim[base + 5];
			case (op)
				32'd1: begin
					store_write(addr, wdata, strb[3:0], resp);
					if (resp !== exp_resp[1:0])
						report_mismatch("lsu_bresp", exp_resp, 32'(resp));
				end
				32'd2: begin
					load_read(addr, rdata, resp);
					if (rdata !== exp_data)
						report_mismatch("lsu_rdata", exp_data, rdata);
					if (resp !== exp_resp[1:0])
						report_mismatch("lsu_rresp", exp_resp, 32'(resp));
				end
				32'd3: begin
					fetch_read(addr, rdata, resp);
					if (rdata !== exp_data)
						report_mismatch("ifu_rdata", exp_data, rdata);
					if (resp !== exp_resp[1:0])
						report_mismatch("ifu_rresp", exp_resp, 32'(resp));
				end
				32'd4: begin
					if (n + 1 >= entry_count || stim[base + 6] != 32'd2) begin
						$display("ERROR: paired fetch in entry %0d is not followed by a load", n);
						error_count++;
					end else begin
						fork
							fetch_read(addr, rdata, resp);
							load_read(stim[base + 7], rdata2, resp2);
						join
						if (rdata !== exp_data)
							report_mismatch("ifu_rdata", exp_data, rdata);
						if (resp !== exp_resp[1:0])
							report_mismatch("ifu_rresp", exp_resp, 32'(resp));
						if (rdata2 !== stim[base + 10])
							report_mismatch("lsu_rdata", stim[base + 10], rdata2);
						if (resp2 !== stim[base + 11][1:0])
							report_mismatch("lsu_rresp", stim[base + 11], 32'(resp2));
						if (!(ifu_done_time < lsu_done_time)) begin
							$display("ERROR at %0t: load answered before the tied fetch", $time);
							error_count++;
						end
						n++;
					end
				end
				32'd5: begin
					load_read(mtime_lo_addr, rdata, resp);
					if (resp !== resp_okay)
						report_mismatch("lsu_rresp", 32'(resp_okay), 32'(resp));
					if (have_mtime && rdata <= last_mtime) begin
						$display("ERROR at %0t: mtime low word %h did not rise above %h",
							$time, rdata, last_mtime);
						error_count++;
					end
					last_mtime = rdata;
					have_mtime = 1'b1;
				end
				default: begin
					$display("ERROR: unknown operation %h in entry %0d", op, n);
					error_count++;
				end
			endcase
		end

		repeat (4) @(posedge clock);
		$display("Errors: %0d", error_count);
		if (error_count == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog/mem_subsys.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_subsys (
	input  wire         clock,
	input  wire         rst_n,

	input  wire  [31:0] ifu_araddr,
	input  wire         ifu_arvalid,
	output wire         ifu_arready,
	output wire  [31:0] ifu_rdata,
	output wire  [1:0]  ifu_rresp,
	output wire         ifu_rvalid,
	input  wire         ifu_rready,

	input  wire  [31:0] lsu_araddr,
	input  wire         lsu_arvalid,
	input  wire  [2:0]  lsu_arsize,
	output wire         lsu_arready,
	output wire  [31:0] lsu_rdata,
	output wire  [1:0]  lsu_rresp,
	output wire         lsu_rvalid,
	input  wire         lsu_rready,

	input  wire  [31:0] lsu_awaddr,
	input  wire         lsu_awvalid,
	input  wire  [2:0]  lsu_awsize,
	output wire         lsu_awready,
	input  wire  [31:0] lsu_wdata,
	input  wire  [3:0]  lsu_wstrb,
	input  wire         lsu_wvalid,
	output wire         lsu_wready,
	output wire  [1:0]  lsu_bresp,
	output wire         lsu_bvalid,
	input  wire         lsu_bready
);

	// System bus.
	wire        io_master_awready, io_master_awvalid;
	wire [31:0] io_master_awaddr;
	wire [2:0]  io_master_awsize;
	wire        io_master_wready, io_master_wvalid, io_master_wlast;
	wire [63:0] io_master_wdata;
	wire [7:0]  io_master_wstrb;
	wire        io_master_bready, io_master_bvalid;
	wire [1:0]  io_master_bresp;
	wire        io_master_arready, io_master_arvalid;
	wire [31:0] io_master_araddr;
	wire [2:0]  io_master_arsize;
	wire        io_master_rready, io_master_rvalid;
	wire [1:0]  io_master_rresp;
	wire [63:0] io_master_rdata;

	// CLINT read port.
	wire [31:0] clint_araddr, clint_rdata;
	wire        clint_arvalid, clint_arready;
	wire [1:0]  clint_rresp;
	wire        clint_rvalid, clint_rready;

	xbar u_xbar (.*);

	clint u_clint (
		.clock   (clock),
		.rst_n   (rst_n),
		.araddr  (clint_araddr),
		.arvalid (clint_arvalid),
		.arready (clint_arready),
		.rdata   (clint_rdata),
		.rresp   (clint_rresp),
		.rvalid  (clint_rvalid),
		.rready  (clint_rready)
	);

	soc_sram u_sram (
		.clock   (clock),
		.rst_n   (rst_n),
		.awready (io_master_awready),
		.awvalid (io_master_awvalid),
		.awaddr  (io_master_awaddr),
		.awsize  (io_master_awsize),
		.wready  (io_master_wready),
		.wvalid  (io_master_wvalid),
		.wdata   (io_master_wdata),
		.wstrb   (io_master_wstrb),
		.wlast   (io_master_wlast),
		.bready  (io_master_bready),
		.bvalid  (io_master_bvalid),
		.bresp   (io_master_bresp),
		.arready (io_master_arready),
		.arvalid (io_master_arvalid),
		.araddr  (io_master_araddr),
		.arsize  (io_master_arsize),
		.rready  (io_master_rready),
		.rvalid  (io_master_rvalid),
		.rresp   (io_master_rresp),
		.rdata   (io_master_rdata)
	);

endmodule

`default_nettype wire

/* verilog/soc_sram.sv */
`timescale 1ns/100ps
`default_nettype none

module soc_sram
	import xbar_pkg::*;
(
	input  wire         clock,
	input  wire         rst_n,

	output logic        awready,
	input  wire         awvalid,
	input  wire  [31:0] awaddr,
	input  wire  [2:0]  awsize,
	output logic        wready,
	input  wire         wvalid,
	input  wire  [63:0] wdata,
	input  wire  [7:0]  wstrb,
	input  wire         wlast,

	input  wire         bready,
	output logic        bvalid,
	output logic [1:0]  bresp,

	output logic        arready,
	input  wire         arvalid,
	input  wire  [31:0] araddr,
	input  wire  [2:0]  arsize,
	input  wire         rready,
	output logic        rvalid,
	output logic [1:0]  rresp,
	output logic [63:0] rdata
);

	logic [63:0] mem [sram_words];

	sram_rd_state_e rd_state;
	logic [$clog2(sram_read_latency + 1)-1:0] lat_cnt;
	logic [$clog2(sram_words)-1:0] rd_idx_q;
	logic        rd_err_q;
	logic        ar_hs;

	logic        aw_taken, w_taken;
	logic [31:0] aw_addr_q;
	logic [2:0]  aw_size_q;
	logic [63:0] w_data_q;
	logic [7:0]  w_strb_q;
	logic [31:0] wr_addr;
	logic [2:0]  wr_size;
	logic [63:0] wr_data;
	logic [7:0]  wr_strb;
	logic        wr_err;
	logic        wr_fire;

	function automatic logic in_window(input logic [31:0] addr);
		logic [31:0] offset;
		offset = addr - sram_base;
		return offset < 32'(sram_words * 8);
	endfunction

	function automatic logic [$clog2(sram_words)-1:0] word_index(input logic [31:0] addr);
		logic [31:0] offset;
		offset = addr - sram_base;
		return offset[3 +: $clog2(sram_words)];
	endfunction

	assign arready = rd_state == rd_idle;
	assign rvalid  = rd_state == rd_resp;
	assign ar_hs   = arvalid && arready;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			rd_state <= rd_idle;
			lat_cnt  <= '0;
		end else begin
			case (rd_state)
				rd_idle: begin
					if (ar_hs) begin
						rd_state <= rd_wait;
						lat_cnt  <= '0;
					end
				end
				rd_wait: begin
					if (int'(lat_cnt) == sram_read_latency - 1)
						rd_state <= rd_resp;
					else
						lat_cnt <= lat_cnt + 1'b1;
				end
				rd_resp: if (rready) rd_state <= rd_idle;
				default: rd_state <= rd_idle;
			endcase
		end
	end

	// Each write channel is held off once taken, and both while b is pending.
	assign awready = !aw_taken && !bvalid;
	assign wready  = !w_taken && !bvalid;

	assign wr_addr = aw_taken ? aw_addr_q : awaddr;
	assign wr_size = aw_taken ? aw_size_q : awsize;
	assign wr_data = w_taken ? w_data_q : wdata;
	assign wr_strb = w_taken ? w_strb_q : wstrb;
	assign wr_err  = !in_window(wr_addr) || wr_size > 3'd3;
	assign wr_fire = (aw_taken || awvalid && awready) && (w_taken || wvalid && wready);

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			aw_taken <= 1'b0;
			w_taken  <= 1'b0;
			bvalid   <= 1'b0;
		end else if (wr_fire) begin
			aw_taken <= 1'b0;
			w_taken  <= 1'b0;
			bvalid   <= 1'b1;
		end else begin
			if (awvalid && awready)
				aw_taken <= 1'b1;
			if (wvalid && wready)
				w_taken <= 1'b1;
			if (bready)
				bvalid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (ar_hs) begin
			rd_idx_q <= word_index(araddr);
			rd_err_q <= !in_window(araddr) || arsize > 3'd3; // Wider than the bus is refused.
		end
		if (rd_state == rd_wait && int'(lat_cnt) == sram_read_latency - 1) begin
			rdata <= rd_err_q ? 64'h0 : mem[rd_idx_q];
			rresp <= rd_err_q ? resp_decerr : resp_okay;
		end
		if (awvalid && awready) begin
			aw_addr_q <= awaddr;
			aw_size_q <= awsize;
		end
		if (wvalid && wready) begin
			w_data_q <= wdata;
			w_strb_q <= wstrb;
		end
		if (wr_fire) begin
			bresp <= wr_err ? resp_decerr : resp_okay;
			if (!wr_err) begin
				for (int i = 0; i < 8; i++) begin
					if (wr_strb[i])
						mem[word_index(wr_addr)][8*i +: 8] <= wr_data[8*i +: 8];
				end
			end
		end
	end

	a_single_beat: assert property (@(posedge clock) disable iff (!rst_n)
		wvalid |-> wlast);

endmodule

`default_nettype wire

/* verilog/clint.sv */
`timescale 1ns/100ps
`default_nettype none

module clint
	import xbar_pkg::*;
(
	input  wire         clock,
	input  wire         rst_n,
	input  wire  [31:0] araddr,
	input  wire         arvalid,
	output logic        arready,
	output logic [31:0] rdata,
	output logic [1:0]  rresp,
	output logic        rvalid,
	input  wire         rready
);

	logic [63:0] mtime;
	logic        ar_hs;

	assign arready = !rvalid; // One response in flight.
	assign ar_hs   = arvalid && arready;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n)
			mtime <= 64'h0;
		else
			mtime <= mtime + 64'h1;
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n)
			rvalid <= 1'b0;
		else if (ar_hs)
			rvalid <= 1'b1;
		else if (rready)
			rvalid <= 1'b0;
	end

	// Sample the addressed half at the handshake.
	always_ff @(posedge clock) begin
		if (ar_hs) begin
			case (araddr)
				mtime_lo_addr: begin
					rdata <= mtime[31:0];
					rresp <= resp_okay;
				end
				mtime_hi_addr: begin
					rdata <= mtime[63:32];
					rresp <= resp_okay;
				end
				default: begin
					rdata <= 32'h0;
					rresp <= resp_decerr;
				end
			endcase
		end
	end

	a_rvalid_hold: assert property (@(posedge clock) disable iff (!rst_n)
		rvalid && !rready |=> rvalid);

	// The crossbar routes only CLINT-window addresses here.
	a_in_window: assert property (@(posedge clock) disable iff (!rst_n)
		arvalid |-> araddr >= clint_base && araddr <= clint_last);

endmodule

`default_nettype wire

/* verilog/xbar.sv */
`timescale 1ns/100ps
`default_nettype none

module xbar
	import xbar_pkg::*;
(
	input  wire         clock,
	input  wire         rst_n,

	input  wire  [31:0] ifu_araddr,
	input  wire         ifu_arvalid,
	output logic        ifu_arready,

	output logic [31:0] ifu_rdata,
	output logic [1:0]  ifu_rresp,
	output logic        ifu_rvalid,
	input  wire         ifu_rready,

	input  wire  [31:0] lsu_araddr,
	input  wire         lsu_arvalid,
	input  wire  [2:0]  lsu_arsize,
	output logic        lsu_arready,

	output logic [31:0] lsu_rdata,
	output logic [1:0]  lsu_rresp,
	output logic        lsu_rvalid,
	input  wire         lsu_rready,

	input  wire  [31:0] lsu_awaddr,
	input  wire         lsu_awvalid,
	input  wire  [2:0]  lsu_awsize,
	output logic        lsu_awready,

	input  wire  [31:0] lsu_wdata,
	input  wire  [3:0]  lsu_wstrb,
	input  wire         lsu_wvalid,
	output logic        lsu_wready,

	output logic [1:0]  lsu_bresp,
	output logic        lsu_bvalid,
	input  wire         lsu_bready,

	input  wire         io_master_awready,
	output logic        io_master_awvalid,
	output logic [31:0] io_master_awaddr,
	output logic [2:0]  io_master_awsize,
	input  wire         io_master_wready,
	output logic        io_master_wvalid,
	output logic [63:0] io_master_wdata,
	output logic [7:0]  io_master_wstrb,
	output logic        io_master_wlast,

	output logic        io_master_bready,
	input  wire         io_master_bvalid,
	input  wire  [1:0]  io_master_bresp,

	input  wire         io_master_arready,
	output logic        io_master_arvalid,
	output logic [31:0] io_master_araddr,
	output logic [2:0]  io_master_arsize,
	output logic        io_master_rready,
	input  wire         io_master_rvalid,
	input  wire  [1:0]  io_master_rresp,
	input  wire  [63:0] io_master_rdata,

	output logic [31:0] clint_araddr,
	output logic        clint_arvalid,
	input  wire         clint_arready,
	input  wire  [31:0] clint_rdata,
	input  wire  [1:0]  clint_rresp,
	input  wire         clint_rvalid,
	output logic        clint_rready
);

	read_owner_e owner_q;
	logic        ar_done_q;   // Request of the current grant already sent.
	logic        rsp_clint_q; // Response comes from the CLINT.
	logic        rsp_hi_q;    // Upper 32-bit lane of the bus data.
	logic        ifu_own, lsu_own;
	logic        lsu_to_clint;
	logic        ar_hs;
	logic [31:0] bus_lane;

	assign ifu_own      = owner_q == owner_ifu;
	assign lsu_own      = owner_q == owner_lsu;
	assign lsu_to_clint = (lsu_araddr >= clint_base) && (lsu_araddr <= clint_last);

	// Fetch always goes to the system bus.
	assign io_master_arvalid = !ar_done_q &&
		(ifu_own && ifu_arvalid || lsu_own && !lsu_to_clint && lsu_arvalid);
	assign clint_arvalid     = !ar_done_q && lsu_own && lsu_to_clint && lsu_arvalid;
	assign io_master_araddr  = ifu_own ? ifu_araddr : lsu_araddr;
	assign io_master_arsize  = ifu_own ? 3'b010 : lsu_arsize;
	assign clint_araddr      = lsu_araddr;

	assign ifu_arready = ifu_own && !ar_done_q && io_master_arready;
	assign lsu_arready = lsu_own && !ar_done_q &&
		(lsu_to_clint ? clint_arready : io_master_arready);

	assign ar_hs = io_master_arvalid && io_master_arready || clint_arvalid && clint_arready;

	// Response return.
	assign bus_lane   = rsp_hi_q ? io_master_rdata[63:32] : io_master_rdata[31:0];
	assign ifu_rvalid = ifu_own && ar_done_q && io_master_rvalid;
	assign ifu_rdata  = bus_lane;
	assign ifu_rresp  = io_master_rresp;
	assign lsu_rvalid = lsu_own && ar_done_q && (rsp_clint_q ? clint_rvalid : io_master_rvalid);
	assign lsu_rdata  = rsp_clint_q ? clint_rdata : bus_lane;
	assign lsu_rresp  = rsp_clint_q ? clint_rresp : io_master_rresp;

	assign io_master_rready = ar_done_q && !rsp_clint_q &&
		(ifu_own && ifu_rready || lsu_own && lsu_rready);
	assign clint_rready     = ar_done_q && rsp_clint_q && lsu_own && lsu_rready;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			owner_q     <= owner_none;
			ar_done_q   <= 1'b0;
			rsp_clint_q <= 1'b0;
			rsp_hi_q    <= 1'b0;
		end else begin
			case (owner_q)
				owner_none: begin
					if (ifu_arvalid)
						owner_q <= owner_ifu; // Fetch wins a tie.
					else if (lsu_arvalid)
						owner_q <= owner_lsu;
				end
				owner_ifu: if (ifu_rvalid && ifu_rready) owner_q <= owner_none;
				owner_lsu: if (lsu_rvalid && lsu_rready) owner_q <= owner_none;
				default:   owner_q <= owner_none;
			endcase
			if (ar_hs) begin
				ar_done_q   <= 1'b1;
				rsp_clint_q <= clint_arvalid;
				rsp_hi_q    <= io_master_araddr[2];
			end else if (ifu_rvalid && ifu_rready || lsu_rvalid && lsu_rready) begin
				ar_done_q <= 1'b0;
			end
		end
	end

	// Writes bypass arbitration and land on the lane picked by awaddr bit 2.
	assign lsu_awready       = io_master_awready;
	assign io_master_awvalid = lsu_awvalid;
	assign io_master_awaddr  = lsu_awaddr;
	assign io_master_awsize  = lsu_awsize;
	assign lsu_wready        = io_master_wready;
	assign io_master_wvalid  = lsu_wvalid;
	assign io_master_wdata   = lsu_awaddr[2] ? {lsu_wdata, 32'h0} : {32'h0, lsu_wdata};
	assign io_master_wstrb   = lsu_awaddr[2] ? {lsu_wstrb, 4'h0} : {4'h0, lsu_wstrb};
	assign io_master_wlast   = lsu_wvalid; // Single beat.
	assign io_master_bready  = lsu_bready;
	assign lsu_bvalid        = io_master_bvalid;
	assign lsu_bresp         = io_master_bresp;

	// No slave may answer a read that the crossbar has not granted.
	a_rvalid_granted: assert property (@(posedge clock) disable iff (!rst_n)
		(io_master_rvalid || clint_rvalid) |-> owner_q != owner_none && ar_done_q);

	// A CLINT answer belongs to a load/store read sent to the CLINT.
	a_clint_lsu_only: assert property (@(posedge clock) disable iff (!rst_n)
		clint_rvalid |-> owner_q == owner_lsu && rsp_clint_q);

endmodule

`default_nettype wire

/* verilog/xbar_pkg.sv */
`default_nettype none

package xbar_pkg;

	// CLINT window on the core-local side.
	localparam logic [31:0] clint_base    = 32'h0200_0000;
	localparam logic [31:0] clint_last    = 32'h0200_ffff;
	localparam logic [31:0] mtime_lo_addr = 32'h0200_bff8;
	localparam logic [31:0] mtime_hi_addr = 32'h0200_bffc;

	// System-bus SRAM window.
	localparam logic [31:0] sram_base         = 32'h8000_0000;
	localparam int          sram_words        = 256; // 64-bit words.
	localparam int          sram_read_latency = 2;   // ar handshake to rvalid.

	localparam logic [1:0] resp_okay   = 2'b00;
	localparam logic [1:0] resp_decerr = 2'b11;

	// Read grant held by the crossbar.
	typedef enum logic [1:0] {
		owner_none,
		owner_ifu,
		owner_lsu
	} read_owner_e;

	typedef enum logic [1:0] {
		rd_idle,
		rd_wait,
		rd_resp
	} sram_rd_state_e;

endpackage

`default_nettype wire
